//--- nts_engine.f
src/nts_ntp_pkg.sv
src/nts_engine_pkg.sv
src/nts_word_counter.sv
src/nts_rx_buffer.sv
src/nts_parser_ctrl.sv
src/nts_timestamp.sv
src/nts_tx_buffer.sv
src/nts_engine.sv
tests/tb_nts_engine.sv

//--- src/nts_engine.sv
/*
 * NTP server engine
 * Checks one client request from the receive dispatcher and places the
 * server reply in the transmit buffer
 */
module nts_engine (
  input  logic                             i_clk,
  input  logic                             i_arst_n,
  input  nts_ntp_pkg::ntp_timestamp_t      i_ntp_time,
  input  nts_engine_pkg::rx_dispatch_in_t  i_rx,
  output nts_engine_pkg::rx_dispatch_out_t o_rx,
  input  nts_engine_pkg::tx_dispatch_in_t  i_tx,
  output nts_engine_pkg::tx_dispatch_out_t o_tx,
  output logic                             o_busy
);
  import nts_ntp_pkg::*;
  import nts_engine_pkg::*;

  logic           rx_fifo_rd_en;
  logic           rx_release;
  logic           word_pop;
  logic           parser_copy;
  logic           parser_clear;
  logic           cnt_clear;
  logic           cnt_incr;
  logic           cnt_overflow;
  word_idx_t      cnt_idx;
  client_fields_t client_fields;
  logic           ts_record;
  logic           ts_reply;
  logic           ts_wr_en;
  word_idx_t      ts_wr_idx;
  ntp_word_t      ts_wr_data;
  logic           tx_full;

  assign o_rx = '{packet_read_discard: rx_release, fifo_rd_en: rx_fifo_rd_en};

  // ------------------------------------------------------------------
  // Units
  // ------------------------------------------------------------------
  nts_word_counter u_counter (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_clear(cnt_clear), .i_incr(cnt_incr),
    .o_idx(cnt_idx), .o_overflow(cnt_overflow)
  );

  nts_rx_buffer u_rx_buffer (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_rx(i_rx), .o_fifo_rd_en(rx_fifo_rd_en),
    .i_copy(parser_copy), .i_clear(parser_clear), .i_idx(cnt_idx),
    .o_word_pop(word_pop), .o_fields(client_fields)
  );

  nts_parser_ctrl u_parser (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_rx_packet_available(i_rx.packet_available),
    .i_rx_fifo_empty(i_rx.fifo_empty),
    .i_word_pop(word_pop), .i_fields(client_fields),
    .i_idx(cnt_idx), .i_overflow(cnt_overflow), .i_tx_full(tx_full),
    .o_copy(parser_copy), .o_clear(parser_clear),
    .o_cnt_clear(cnt_clear), .o_cnt_incr(cnt_incr),
    .o_record(ts_record), .o_reply(ts_reply),
    .o_packet_read_discard(rx_release), .o_busy(o_busy)
  );

  nts_timestamp u_timestamp (
    .i_clk(i_clk), .i_arst_n(i_arst_n), .i_ntp_time(i_ntp_time),
    .i_record(ts_record), .i_reply(ts_reply),
    .i_idx(cnt_idx), .i_fields(client_fields),
    .o_wr_en(ts_wr_en), .o_wr_idx(ts_wr_idx), .o_wr_data(ts_wr_data)
  );

  nts_tx_buffer u_tx_buffer (
    .i_clk(i_clk), .i_arst_n(i_arst_n),
    .i_wr_en(ts_wr_en), .i_wr_idx(ts_wr_idx), .i_wr_data(ts_wr_data),
    .i_tx(i_tx), .o_tx(o_tx), .o_full(tx_full)
  );

endmodule

//--- src/nts_engine_pkg.sv
/*
 * Engine definitions
 * Dispatch port bundles, word index, client field bundle and the
 * states of the parser
 */
package nts_engine_pkg;

  typedef logic [2:0] word_idx_t;

  localparam logic [7:0] LAST_WORD_VALID = 8'hFF;  // All eight bytes present

  // ------------------------------------------------------------------
  // Dispatch sides
  // ------------------------------------------------------------------
  typedef struct packed {
    logic                   packet_available;
    logic                   fifo_empty;
    logic [7:0]             data_valid;  // Byte valids of the last word
    nts_ntp_pkg::ntp_word_t rd_data;
  } rx_dispatch_in_t;

  typedef struct packed {
    logic packet_read_discard;
    logic fifo_rd_en;
  } rx_dispatch_out_t;

  typedef struct packed {
    logic packet_read;
    logic fifo_rd_en;
  } tx_dispatch_in_t;

  typedef struct packed {
    logic                   packet_available;
    logic                   fifo_empty;
    nts_ntp_pkg::ntp_word_t rd_data;
  } tx_dispatch_out_t;

  // Fields taken from a client request
  typedef struct packed {
    logic [2:0]                  version;
    logic [2:0]                  mode;
    logic [7:0]                  poll;
    nts_ntp_pkg::ntp_timestamp_t transmit_ts;
    logic                        length_ok;
  } client_fields_t;

  typedef enum logic [3:0] {
    STATE_EMPTY   = 4'h1,
    STATE_COPY    = 4'h2,
    STATE_CHECK   = 4'h3,
    STATE_REPLY   = 4'h4,
    STATE_WAIT_TX = 4'h5,
    STATE_DISCARD = 4'hc
  } parser_state_t;

endpackage

//--- src/nts_ntp_pkg.sv
/*
 * NTP packet format
 * Word, timestamp and header types of the 48 byte NTP packet and the
 * fixed fields that this server puts in every reply
 */
package nts_ntp_pkg;

  // ------------------------------------------------------------------
  // Packet layout
  // ------------------------------------------------------------------
  localparam int NTP_WORDS = 6;  // 48 bytes as 64 bit words

  typedef logic [63:0] ntp_word_t;

  typedef struct packed {
    logic [31:0] seconds;
    logic [31:0] fraction;
  } ntp_timestamp_t;

  typedef struct packed {
    logic [1:0]  leap;        // Leap indicator
    logic [2:0]  version;
    logic [2:0]  mode;
    logic [7:0]  stratum;
    logic [7:0]  poll;
    logic [7:0]  precision;
    logic [31:0] root_delay;
  } ntp_header_fields_t;

  // First packet word taken either raw or field by field
  typedef union packed {
    ntp_word_t          raw;
    ntp_header_fields_t fields;
  } ntp_header_word_u;

  // ------------------------------------------------------------------
  // Modes and fixed reply fields
  // ------------------------------------------------------------------
  localparam logic [2:0]  NTP_MODE_CLIENT = 3'd3;
  localparam logic [2:0]  NTP_MODE_SERVER = 3'd4;
  localparam logic [7:0]  NTP_STRATUM     = 8'd1;          // Primary server
  localparam logic [7:0]  NTP_PRECISION   = 8'hEC;         // About 2^-20 s
  localparam logic [31:0] NTP_REF_ID      = 32'h4C4F434C;  // "LOCL"
  localparam logic [31:0] NTP_ROOT_DISP   = 32'h0;

endpackage

//--- src/nts_parser_ctrl.sv
/*
 * Parser control
 * FSM that copies one request, checks it, starts the reply or drops
 * the request, and then releases the receive packet
 */
module nts_parser_ctrl (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  logic                           i_rx_packet_available,
  input  logic                           i_rx_fifo_empty,
  input  logic                           i_word_pop,
  input  nts_engine_pkg::client_fields_t i_fields,
  input  nts_engine_pkg::word_idx_t      i_idx,
  input  logic                           i_overflow,
  input  logic                           i_tx_full,
  output logic                           o_copy,
  output logic                           o_clear,
  output logic                           o_cnt_clear,
  output logic                           o_cnt_incr,
  output logic                           o_record,
  output logic                           o_reply,
  output logic                           o_packet_read_discard,
  output logic                           o_busy
);
  import nts_ntp_pkg::*;
  import nts_engine_pkg::*;

  parser_state_t state;
  parser_state_t state_next;
  logic          start;
  logic          accept;
  logic          done;

  // Only start when there is room for the reply
  assign start = (state == STATE_EMPTY) && i_rx_packet_available && !i_tx_full;

  assign accept = i_fields.length_ok && !i_overflow &&
                  (i_fields.mode == NTP_MODE_CLIENT) &&
                  (i_fields.version == 3'd3 || i_fields.version == 3'd4);

  // Release after a reject, or once the reply sits in the tx buffer
  assign done = (state == STATE_CHECK && !accept) ||
                (state == STATE_WAIT_TX && i_tx_full);

  // ------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      STATE_EMPTY:   if (start) state_next = STATE_COPY;
      STATE_COPY:    if (i_rx_fifo_empty) state_next = STATE_CHECK;
      STATE_CHECK:   state_next = accept ? STATE_REPLY : STATE_DISCARD;
      STATE_REPLY:   if (i_idx == word_idx_t'(NTP_WORDS - 1)) state_next = STATE_WAIT_TX;
      STATE_WAIT_TX: if (i_tx_full) state_next = STATE_EMPTY;
      STATE_DISCARD: state_next = STATE_EMPTY;
      default:       state_next = STATE_EMPTY;
    endcase
  end

  // ------------------------------------------------------------------
  // Strobes to the datapath
  // ------------------------------------------------------------------
  assign o_copy      = (state == STATE_COPY);
  assign o_reply     = (state == STATE_REPLY);
  assign o_clear     = start;
  assign o_cnt_clear = start || (state == STATE_CHECK && accept);  // Reply counts from 0
  assign o_cnt_incr  = (o_copy && i_word_pop) || o_reply;
  assign o_record    = o_copy && i_word_pop && (i_idx == 3'd0);    // First word popped

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      state                 <= STATE_EMPTY;
      o_packet_read_discard <= 1'b0;
      o_busy                <= 1'b0;
    end
    else
    begin
      state                 <= state_next;
      o_packet_read_discard <= done;  // One cycle pulse
      if (start)
        o_busy <= 1'b1;
      else if (done)
        o_busy <= 1'b0;
    end
  end

endmodule

//--- src/nts_rx_buffer.sv
/*
 * Receive buffer
 * Pops the request from the show-ahead dispatch FIFO and keeps the
 * client fields that the check and the reply need
 */
module nts_rx_buffer (
  input  logic                            i_clk,
  input  logic                            i_arst_n,
  input  nts_engine_pkg::rx_dispatch_in_t i_rx,
  output logic                            o_fifo_rd_en,
  input  logic                            i_copy,
  input  logic                            i_clear,
  input  nts_engine_pkg::word_idx_t       i_idx,
  output logic                            o_word_pop,
  output nts_engine_pkg::client_fields_t  o_fields
);
  import nts_ntp_pkg::*;
  import nts_engine_pkg::*;

  ntp_header_word_u header;
  logic [2:0]       client_version;
  logic [2:0]       client_mode;
  logic [7:0]       client_poll;
  ntp_timestamp_t   client_transmit;
  logic             length_ok;

  // Head word is valid while the FIFO is not empty
  assign o_fifo_rd_en = i_copy && i_rx.packet_available && !i_rx.fifo_empty;
  assign o_word_pop   = o_fifo_rd_en;

  assign header.raw = i_rx.rd_data;

  always_ff @(posedge i_clk)
  begin
    if (o_word_pop && i_idx == 3'd0)
    begin
      client_version <= header.fields.version;
      client_mode    <= header.fields.mode;
      client_poll    <= header.fields.poll;
    end
    if (o_word_pop && i_idx == word_idx_t'(NTP_WORDS - 1))
      client_transmit <= i_rx.rd_data;  // Becomes the reply origin
  end

  // The counter already points past the last pop at the end of a packet
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      length_ok <= 1'b0;
    else if (i_clear)
      length_ok <= 1'b0;
    else if (i_copy && i_rx.fifo_empty)
      length_ok <= (i_idx == word_idx_t'(NTP_WORDS)) &&
                   (i_rx.data_valid == LAST_WORD_VALID);
  end

  assign o_fields = '{version:     client_version,
                      mode:        client_mode,
                      poll:        client_poll,
                      transmit_ts: client_transmit,
                      length_ok:   length_ok};

endmodule

//--- src/nts_timestamp.sv
/*
 * Timestamp unit
 * Samples NTP time on receive and at reply start, and forms the six
 * reply words that go to the transmit buffer
 */
module nts_timestamp (
  input  logic                           i_clk,
  input  logic                           i_arst_n,
  input  nts_ntp_pkg::ntp_timestamp_t    i_ntp_time,
  input  logic                           i_record,
  input  logic                           i_reply,
  input  nts_engine_pkg::word_idx_t      i_idx,
  input  nts_engine_pkg::client_fields_t i_fields,
  output logic                           o_wr_en,
  output nts_engine_pkg::word_idx_t      o_wr_idx,
  output nts_ntp_pkg::ntp_word_t         o_wr_data
);
  import nts_ntp_pkg::*;

  ntp_timestamp_t     rx_time;
  ntp_timestamp_t     tx_time;
  ntp_header_fields_t header;
  ntp_word_t          word;

  always_comb
  begin
    header.leap       = 2'b00;              // No warning
    header.version    = i_fields.version;   // Echo the client
    header.mode       = NTP_MODE_SERVER;
    header.stratum    = NTP_STRATUM;
    header.poll       = i_fields.poll;
    header.precision  = NTP_PRECISION;
    header.root_delay = 32'h0;
  end

  // Reply word by index
  always_comb
  begin
    case (i_idx)
      3'd0:    word = header;
      3'd1:    word = {NTP_ROOT_DISP, NTP_REF_ID};
      3'd2:    word = rx_time;               // Reference
      3'd3:    word = i_fields.transmit_ts;  // Origin
      3'd4:    word = rx_time;               // Receive
      3'd5:    word = tx_time;
      default: word = 64'h0;
    endcase
  end

  always_ff @(posedge i_clk)
  begin
    if (i_record)
      rx_time <= i_ntp_time;
    if (i_reply && i_idx == 3'd0)
      tx_time <= i_ntp_time;
    o_wr_idx  <= i_idx;
    o_wr_data <= word;
  end

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      o_wr_en <= 1'b0;
    else
      o_wr_en <= i_reply;
  end

endmodule

//--- src/nts_tx_buffer.sv
/*
 * Transmit buffer
 * Holds one six word reply and hands it to the transmit dispatcher
 * one word per read strobe
 */
module nts_tx_buffer (
  input  logic                             i_clk,
  input  logic                             i_arst_n,
  input  logic                             i_wr_en,
  input  nts_engine_pkg::word_idx_t        i_wr_idx,
  input  nts_ntp_pkg::ntp_word_t           i_wr_data,
  input  nts_engine_pkg::tx_dispatch_in_t  i_tx,
  output nts_engine_pkg::tx_dispatch_out_t o_tx,
  output logic                             o_full
);
  import nts_ntp_pkg::*;
  import nts_engine_pkg::*;

  ntp_word_t mem [NTP_WORDS];
  word_idx_t rd_ptr;
  logic      full;
  logic      empty;
  ntp_word_t head;

  always_ff @(posedge i_clk)
  begin
    if (i_wr_en)
      mem[i_wr_idx] <= i_wr_data;
  end

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      full   <= 1'b0;
      rd_ptr <= 3'd0;
    end
    else if (i_tx.packet_read)
    begin
      full   <= 1'b0;  // Buffer free for the next reply
      rd_ptr <= 3'd0;
    end
    else if (i_wr_en && i_wr_idx == word_idx_t'(NTP_WORDS - 1))
    begin
      full   <= 1'b1;  // Last word written
      rd_ptr <= 3'd0;
    end
    else if (i_tx.fifo_rd_en && !empty)
      rd_ptr <= rd_ptr + 3'd1;
  end

  // Empty before a reply and after its last word was read
  assign empty = !full || (rd_ptr == word_idx_t'(NTP_WORDS));
  assign head  = (rd_ptr < NTP_WORDS) ? mem[rd_ptr] : 64'h0;

  assign o_full = full;
  assign o_tx   = '{packet_available: full, fifo_empty: empty, rd_data: head};

endmodule

//--- src/nts_word_counter.sv
/*
 * Word counter
 * Counts packet words while a request is copied and while the reply is
 * written, with a sticky flag for requests that run too long
 */
module nts_word_counter (
  input  logic                      i_clk,
  input  logic                      i_arst_n,
  input  logic                      i_clear,
  input  logic                      i_incr,
  output nts_engine_pkg::word_idx_t o_idx,
  output logic                      o_overflow
);
  import nts_ntp_pkg::*;

  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_idx      <= 3'd0;
      o_overflow <= 1'b0;
    end
    else if (i_clear)
    begin
      o_idx      <= 3'd0;
      o_overflow <= 1'b0;
    end
    else if (i_incr)
    begin
      if (o_idx >= NTP_WORDS)
        o_overflow <= 1'b1;     // Past the last word of a packet
      if (o_idx != 3'd7)
        o_idx <= o_idx + 3'd1;  // Saturates so a long packet never wraps
    end
  end

endmodule

//--- tests/tb_nts_engine.sv
/*
 * NTP engine testbench
 * Feeds client requests through a model of the receive FIFO, reads the
 * replies from the transmit buffer and checks them word by word
 */
module tb_nts_engine;
  timeunit 1ns;
  timeprecision 1ps;

  import nts_ntp_pkg::*;
  import nts_engine_pkg::*;

  localparam int TIMEOUT = 200;  // Cycles allowed for any wait

  logic             clk;
  logic             arst_n;
  ntp_timestamp_t   ntp_time;
  rx_dispatch_in_t  rx_in;
  rx_dispatch_out_t rx_out;
  tx_dispatch_in_t  tx_in;
  tx_dispatch_out_t tx_out;
  logic             busy;

  // Receive FIFO model with one entry per queued packet in rx_len and rx_dv
  ntp_word_t       rx_words[$];
  int              rx_len[$];
  logic [7:0]      rx_dv[$];
  int              rx_popped;
  int              pops;
  int              releases;
  logic            pend_pop;
  logic            pend_release;
  tx_dispatch_in_t tx_cmd;
  ntp_timestamp_t  time_cmd;
  integer          seed;

  nts_engine u_dut (
    .i_clk(clk), .i_arst_n(arst_n), .i_ntp_time(ntp_time),
    .i_rx(rx_in), .o_rx(rx_out), .i_tx(tx_in), .o_tx(tx_out), .o_busy(busy)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic compare_word(input string what, input ntp_word_t got, input ntp_word_t exp);
    if (got !== exp)
      fail_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic compare_tx_status(input tx_dispatch_out_t got, input tx_dispatch_out_t exp);
    if (got.packet_available !== exp.packet_available || got.fifo_empty !== exp.fifo_empty)
      fail_run($sformatf("Fail at %0d ns: tx available/empty are %b/%b, expected %b/%b",
                         $time, got.packet_available, got.fifo_empty,
                         exp.packet_available, exp.fifo_empty));
  endtask

  task automatic compare_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp));
  endtask

  // ------------------------------------------------------------------
  // Receive FIFO model and cycle step
  // ------------------------------------------------------------------
  task automatic drive_rx();
    logic empty;
    empty = (rx_len.size() == 0) || (rx_popped == rx_len[0]);
    rx_in.packet_available = (rx_len.size() != 0);
    rx_in.fifo_empty       = empty;
    rx_in.data_valid       = (rx_len.size() != 0) ? rx_dv[0] : 8'hFF;
    rx_in.rd_data          = empty ? 64'h0 : rx_words[0];  // Show-ahead head word
  endtask

  task automatic step();
    @(negedge clk);
    if (pend_pop)  // Word taken at the last rising edge
    begin
      rx_words.delete(0);
      rx_popped++;
      pops++;
    end
    if (pend_release)
    begin
      if (rx_len.size() == 0 || rx_popped != rx_len[0])
        fail_run("Receive packet was released with no packet queued or words still unread");
      else
      begin
        rx_len.delete(0);
        rx_dv.delete(0);
        rx_popped = 0;
        releases++;
      end
    end
    drive_rx();
    tx_in    = tx_cmd;
    ntp_time = time_cmd;
    #1;
    pend_pop     = rx_out.fifo_rd_en;
    pend_release = rx_out.packet_read_discard;
  endtask

  task automatic queue_request(input logic [2:0] version, input logic [2:0] mode,
                               input logic [7:0] poll, input ntp_word_t origin,
                               input int n_words, input logic [7:0] last_valid);
    ntp_word_t w;
    for (int i = 0; i < n_words; i++)
    begin
      case (i)
        0:       w = {2'b00, version, mode, 8'd0, poll, 8'hFA, 32'h0};  // Client header
        5:       w = origin;                                           // Client transmit
        default: w = {16'hC1E0, 16'(i), 32'h0};
      endcase
      rx_words.push_back(w);
    end
    rx_len.push_back(n_words);
    rx_dv.push_back(last_valid);
  endtask

  // Expected server reply word
  function automatic ntp_word_t reply_word(input int idx, input logic [2:0] version,
                                           input logic [7:0] poll, input ntp_word_t origin,
                                           input ntp_word_t t);
    case (idx)
      0:       reply_word = {2'b00, version, 3'd4, 8'd1, poll, 8'hEC, 32'h0};
      1:       reply_word = {32'h0, 32'h4C4F434C};  // Root dispersion, reference id
      3:       reply_word = origin;
      default: reply_word = t;                      // Reference, receive, transmit
    endcase
  endfunction

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------
  task automatic wait_reply();
    int n;
    n = 0;
    while (tx_out.packet_available !== 1'b1)
    begin
      if (n == TIMEOUT)
        fail_run("Timed out waiting for a reply in the transmit buffer");
      step();
      n++;
    end
  endtask

  task automatic read_reply(input logic [2:0] version, input logic [7:0] poll,
                            input ntp_word_t origin, input ntp_timestamp_t t);
    wait_reply();
    for (int i = 0; i < 6; i++)
    begin
      compare_tx_status(tx_out, tx_dispatch_out_t'{1'b1, 1'b0, 64'h0});
      compare_word($sformatf("reply word %0d", i), tx_out.rd_data,
                   reply_word(i, version, poll, origin, t));
      tx_cmd.fifo_rd_en = 1'b1;
      step();
      tx_cmd.fifo_rd_en = 1'b0;
      step();
    end
    compare_tx_status(tx_out, tx_dispatch_out_t'{1'b1, 1'b1, 64'h0});  // Read out, still held
  endtask

  task automatic free_reply();
    tx_cmd.packet_read = 1'b1;
    step();
    tx_cmd.packet_read = 1'b0;
    step();
    compare_tx_status(tx_out, tx_dispatch_out_t'{1'b0, 1'b1, 64'h0});
  endtask

  task automatic valid_request(input logic [2:0] version, input logic [7:0] poll,
                               input ntp_timestamp_t t);
    ntp_word_t origin;
    int        rel;
    origin   = {$random(seed), $random(seed)};
    time_cmd = t;  // Held for the whole request
    rel      = releases;
    queue_request(version, 3'd3, poll, origin, 6, 8'hFF);
    read_reply(version, poll, origin, t);
    if (releases != rel + 1)
      fail_run("Valid request was not released by a single packet_read_discard pulse");
    free_reply();
  endtask

  task automatic bad_request(input logic [2:0] version, input logic [2:0] mode,
                             input int n_words, input logic [7:0] last_valid,
                             input string what);
    int n;
    int rel;
    rel = releases;
    queue_request(version, mode, 8'd6, {$random(seed), $random(seed)}, n_words, last_valid);
    n = 0;
    while (releases == rel)
    begin
      if (n == TIMEOUT)
        fail_run({"Timed out waiting for the discard of ", what});
      compare_bit("tx packet_available", tx_out.packet_available, 1'b0);
      step();
      n++;
    end
    for (int i = 0; i < 20; i++)  // No reply may follow the discard
    begin
      compare_bit("tx packet_available", tx_out.packet_available, 1'b0);
      step();
    end
    compare_bit("o_busy", busy, 1'b0);
  endtask

  task automatic back_pressure();
    ntp_word_t      origin_a;
    ntp_word_t      origin_b;
    ntp_timestamp_t t_a;
    ntp_timestamp_t t_b;
    int             popped;
    origin_a = {$random(seed), $random(seed)};
    origin_b = {$random(seed), $random(seed)};
    t_a      = 64'hE8A1_0010_4000_0000;
    t_b      = 64'hE8A1_0011_C000_0000;
    time_cmd = t_a;
    queue_request(3'd4, 3'd3, 8'd6, origin_a, 6, 8'hFF);
    queue_request(3'd3, 3'd3, 8'd10, origin_b, 6, 8'hFF);
    wait_reply();
    popped = pops;
    repeat (20) step();
    time_cmd = t_b;  // Second request must see the new time
    if (pops != popped)
      fail_run("Second request was read while the reply buffer was full");
    read_reply(3'd4, 8'd6, origin_a, t_a);
    if (pops != popped)
      fail_run("Second request was read before the first reply was freed");
    free_reply();
    read_reply(3'd3, 8'd10, origin_b, t_b);
    free_reply();
  endtask

  initial
  begin
    seed         = 32'h41b6_e71d;
    pops         = 0;
    releases     = 0;
    rx_popped    = 0;
    pend_pop     = 1'b0;
    pend_release = 1'b0;
    tx_cmd       = '0;
    time_cmd     = '0;
    arst_n       = 1'b0;
    ntp_time     = '0;
    tx_in        = '0;
    drive_rx();
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    step();

    compare_bit("o_busy", busy, 1'b0);
    compare_bit("rx fifo_rd_en", rx_out.fifo_rd_en, 1'b0);
    compare_bit("rx packet_read_discard", rx_out.packet_read_discard, 1'b0);
    compare_tx_status(tx_out, tx_dispatch_out_t'{1'b0, 1'b1, 64'h0});

    valid_request(3'd4, 8'd6, 64'hE8A1_0000_8000_0000);
    valid_request(3'd3, 8'd4, 64'hE8A1_0002_2000_0000);
    bad_request(3'd4, 3'd4, 6, 8'hFF, "a mode 4 request");
    bad_request(3'd2, 3'd3, 6, 8'hFF, "a version 2 request");
    bad_request(3'd4, 3'd3, 5, 8'hFF, "a five word request");
    bad_request(3'd4, 3'd3, 6, 8'h0F, "a request with a partial last word");
    valid_request(3'd4, 8'd8, 64'hE8A1_0005_0000_0001);
    back_pressure();

    $display("PASS: all tests");
    $finish;
  end

endmodule
